/* Makefile */
VERILATOR ?= verilator
TOP       := serial_bus_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
hw/serial_bus_pkg.sv
hw/serial_link_if.sv
hw/bus_master.sv
hw/bus_slave.sv
hw/bus_router.sv
hw/session_ctrl.sv
hw/serial_bus_top.sv
sim/tb_clock.sv
sim/serial_bus_tb.sv

/* hw/bus_master.sv */
`default_nettype none

module bus_master import serial_bus_pkg::*; (
    input  logic          clk,
    input  logic          rstN,
    input  logic          start,
    input  rw_op_e        rw,
    input  slave_id_t     slave_id,
    input  addr_t         first_addr,
    input  addr_t         last_addr,
    input  logic          load_en,
    input  addr_t         load_addr,
    input  word_t         load_data,
    input  logic          load_sel_match,
    input  addr_t         rd_addr,
    output word_t         rd_data,
    output logic          req,
    output slave_id_t     req_slave,
    input  logic          gnt,
    output logic          done,
    serial_link_if.master link
);

    localparam int CNT_W = $clog2(HEADER_BITS);

    typedef enum logic [2:0] {m_idle, m_req, m_hdr, m_wr, m_rd} master_state_e;

    master_state_e          state;
    word_t                  mem [2**ADDR_W];
    logic [HEADER_BITS-1:0] hdr_sr;
    word_t                  tx_sr;
    word_t                  rx_sr;
    word_t                  rx_word;
    logic [CNT_W-1:0]       cnt;     // bit position in header or word
    addr_t                  ptr;     // current memory word
    logic                   hdr_end;
    logic                   word_end;
    logic                   rx_store;

    assign hdr_end  = (cnt == CNT_W'(HEADER_BITS - 1));
    assign word_end = (cnt == CNT_W'(DATA_W - 1));
    assign rx_word  = {link.rdata, rx_sr[DATA_W-1:1]};
    assign rx_store = (state == m_rd) && link.ready && word_end;

    assign req_slave  = slave_id;   // router latches it with the grant
    assign link.valid = (state == m_hdr) || (state == m_wr);
    assign link.ctrl  = (state == m_hdr) && hdr_sr[0];
    assign link.wdata = (state == m_wr) && tx_sr[0];
    assign link.last  = ((state == m_hdr) && hdr_end && (rw == op_read))
                     || ((state == m_wr) && word_end && (ptr == last_addr));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= m_idle;
            req    <= 1'b0;
            done   <= 1'b0;
            cnt    <= '0;
            ptr    <= '0;
            hdr_sr <= '0;
            tx_sr  <= '0;
            rx_sr  <= '0;
        end else begin
            case (state)
                m_idle: begin
                    if (start) begin
                        done   <= (slave_id == '0);   // no slave, nothing to send
                        hdr_sr <= {last_addr - first_addr, first_addr, rw};
                        ptr    <= first_addr;
                        cnt    <= '0;
                        if (slave_id != '0) begin
                            req   <= 1'b1;
                            state <= m_req;
                        end
                    end
                end
                m_req: begin
                    if (gnt)
                        state <= m_hdr;
                end
                m_hdr: begin
                    hdr_sr <= hdr_sr >> 1;
                    cnt    <= cnt + 1'b1;
                    if (hdr_end) begin
                        cnt <= '0;
                        if (rw == op_write) begin
                            tx_sr <= mem[ptr];
                            state <= m_wr;
                        end else begin
                            state <= m_rd;
                        end
                    end
                end
                m_wr: begin
                    tx_sr <= tx_sr >> 1;
                    cnt   <= cnt + 1'b1;
                    if (word_end) begin
                        cnt <= '0;
                        if (ptr == last_addr) begin
                            req   <= 1'b0;
                            done  <= 1'b1;
                            state <= m_idle;
                        end else begin
                            ptr   <= ptr + 1'b1;
                            tx_sr <= mem[ptr + 1'b1];
                        end
                    end
                end
                m_rd: begin
                    if (link.ready) begin   // slave may leave gaps
                        rx_sr <= rx_word;
                        cnt   <= cnt + 1'b1;
                        if (word_end) begin
                            cnt <= '0;
                            if (ptr == last_addr) begin
                                req   <= 1'b0;
                                done  <= 1'b1;
                                state <= m_idle;
                            end else begin
                                ptr <= ptr + 1'b1;
                            end
                        end
                    end
                end
                default: state <= m_idle;
            endcase
        end
    end

    // operator load has priority, it never overlaps a transfer
    always_ff @(posedge clk) begin
        if (load_en && load_sel_match)
            mem[load_addr] <= load_data;
        else if (rx_store)
            mem[ptr] <= rx_word;
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* hw/bus_router.sv */
`default_nettype none

module bus_router import serial_bus_pkg::*; #(
    parameter int MASTER_COUNT = 2,
    parameter int SLAVE_COUNT  = 3
) (
    input  logic          clk,
    input  logic          rstN,
    input  logic          req [MASTER_COUNT],
    input  slave_id_t     req_slave [MASTER_COUNT],
    output logic          gnt [MASTER_COUNT],
    serial_link_if.slave  m_link [MASTER_COUNT],
    serial_link_if.master s_link [SLAVE_COUNT]
);

    localparam int OWN_W = (MASTER_COUNT > 1) ? $clog2(MASTER_COUNT) : 1;

    logic             held;
    logic             any_req;
    logic [OWN_W-1:0] owner;
    logic [OWN_W-1:0] pick;
    slave_id_t        sid;
    logic             m_ctrl [MASTER_COUNT];
    logic             m_wdata [MASTER_COUNT];
    logic             m_valid [MASTER_COUNT];
    logic             m_last [MASTER_COUNT];
    logic             s_rdata [SLAVE_COUNT];
    logic             s_ready [SLAVE_COUNT];
    logic             f_ctrl, f_wdata, f_valid, f_last;
    logic             b_rdata, b_ready;

    always_comb begin   // fixed priority, master 0 highest
        pick    = '0;
        any_req = 1'b0;
        for (int m = MASTER_COUNT - 1; m >= 0; m--) begin
            if (req[m]) begin
                pick    = OWN_W'(m);
                any_req = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            held  <= 1'b0;
            owner <= '0;
            sid   <= '0;
        end else if (!held) begin
            if (any_req) begin
                held  <= 1'b1;
                owner <= pick;
                sid   <= req_slave[pick];
            end
        end else if (!req[owner]) begin
            held <= 1'b0;   // released one edge after req falls
        end
    end

    always_comb begin
        f_ctrl  = held && m_ctrl[owner];
        f_wdata = held && m_wdata[owner];
        f_valid = held && m_valid[owner];
        f_last  = held && m_last[owner];
        b_rdata = 1'b0;
        b_ready = 1'b0;
        for (int s = 0; s < SLAVE_COUNT; s++) begin
            if (held && (sid == slave_id_t'(s + 1))) begin
                b_rdata = s_rdata[s];
                b_ready = s_ready[s];
            end
        end
    end

    for (genvar m = 0; m < MASTER_COUNT; m++) begin : g_master
        assign gnt[m]          = held && (owner == OWN_W'(m));
        assign m_ctrl[m]       = m_link[m].ctrl;
        assign m_wdata[m]      = m_link[m].wdata;
        assign m_valid[m]      = m_link[m].valid;
        assign m_last[m]       = m_link[m].last;
        assign m_link[m].rdata = gnt[m] && b_rdata;
        assign m_link[m].ready = gnt[m] && b_ready;
    end

    for (genvar s = 0; s < SLAVE_COUNT; s++) begin : g_slave
        logic hit;
        assign hit             = held && (sid == slave_id_t'(s + 1));
        assign s_link[s].ctrl  = hit && f_ctrl;
        assign s_link[s].wdata = hit && f_wdata;
        assign s_link[s].valid = hit && f_valid;
        assign s_link[s].last  = hit && f_last;
        assign s_rdata[s]      = s_link[s].rdata;
        assign s_ready[s]      = s_link[s].ready;
    end

endmodule

`default_nettype wire

/* hw/bus_slave.sv */
`default_nettype none

module bus_slave import serial_bus_pkg::*; #(
    parameter int DEPTH = 256
) (
    input  logic         clk,
    input  logic         rstN,
    serial_link_if.slave link
);

    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(HEADER_BITS);

    typedef enum logic [1:0] {s_hdr, s_wr, s_rd} slave_state_e;

    slave_state_e           state;
    word_t                  mem [DEPTH];
    logic [HEADER_BITS-1:0] hdr_sr;
    logic [HEADER_BITS-1:0] hdr_next;
    word_t                  rx_sr;
    word_t                  rx_word;
    word_t                  tx_sr;
    logic [CNT_W-1:0]       cnt;
    logic [AW-1:0]          ptr;
    logic [AW-1:0]          ptr_inc;
    addr_t                  words_left;   // read words still to send after this one
    logic                   word_end;

    assign hdr_next = {link.ctrl, hdr_sr[HEADER_BITS-1:1]};
    assign rx_word  = {link.wdata, rx_sr[DATA_W-1:1]};
    assign ptr_inc  = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;   // wrap at depth
    assign word_end = (cnt == CNT_W'(DATA_W - 1));

    assign link.ready = (state == s_rd);
    assign link.rdata = (state == s_rd) && tx_sr[0];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= s_hdr;
            cnt        <= '0;
            ptr        <= '0;
            hdr_sr     <= '0;
            rx_sr      <= '0;
            tx_sr      <= '0;
            words_left <= '0;
        end else begin
            case (state)
                s_hdr: begin
                    if (link.valid) begin
                        hdr_sr <= hdr_next;
                        cnt    <= cnt + 1'b1;
                        if (cnt == CNT_W'(HEADER_BITS - 1)) begin
                            cnt        <= '0;
                            ptr        <= AW'(hdr_next[ADDR_W:1]);
                            words_left <= hdr_next[HEADER_BITS-1:ADDR_W+1];
                            if (rw_op_e'(hdr_next[0]) == op_write) begin
                                state <= s_wr;
                            end else begin
                                tx_sr <= mem[AW'(hdr_next[ADDR_W:1])];
                                state <= s_rd;
                            end
                        end
                    end
                end
                s_wr: begin
                    if (link.valid) begin
                        rx_sr <= rx_word;
                        cnt   <= cnt + 1'b1;
                        if (word_end) begin
                            cnt <= '0;
                            ptr <= ptr_inc;
                            if (link.last)
                                state <= s_hdr;
                        end
                    end
                end
                s_rd: begin
                    tx_sr <= tx_sr >> 1;
                    cnt   <= cnt + 1'b1;
                    if (word_end) begin
                        cnt <= '0;
                        if (words_left == '0) begin
                            state <= s_hdr;
                        end else begin
                            words_left <= words_left - 1'b1;
                            ptr        <= ptr_inc;
                            tx_sr      <= mem[ptr_inc];
                        end
                    end
                end
                default: state <= s_hdr;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == s_wr) && link.valid && word_end)
            mem[ptr] <= rx_word;
    end

endmodule

`default_nettype wire

/* hw/serial_bus_pkg.sv */
`default_nettype none

package serial_bus_pkg;

    localparam int DATA_W = 16;
    localparam int ADDR_W = 8;    // master memory holds 2**ADDR_W words

    // rw bit, first address, then word count minus one
    localparam int HEADER_BITS = 1 + 2 * ADDR_W;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;    // addresses and counts
    typedef logic [1:0]        slave_id_t; // 0 selects no slave

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } rw_op_e;

    typedef enum logic [3:0] {
        slave_sel,
        rw_sel,
        first_sel,
        count_sel,
        load_words,
        com_ready,
        communicating,
        com_done
    } session_state_e;

endpackage

`default_nettype wire

/* hw/serial_bus_top.sv */
`default_nettype none

module serial_bus_top import serial_bus_pkg::*; #(
    parameter int MASTER_COUNT     = 2,
    parameter int SLAVE_COUNT      = 3,
    parameter int SLAVE_DEPTHS [3] = '{256, 256, 128}
) (
    input  logic           clk,
    input  logic           rstN,
    input  logic           step,
    input  logic           next_addr,
    input  word_t          value,
    output session_state_e state,
    output word_t          rd_data [MASTER_COUNT]
);

    localparam int IDX_W = (MASTER_COUNT > 1) ? $clog2(MASTER_COUNT) : 1;

    logic             start;
    logic             load_en;
    logic [IDX_W-1:0] load_sel;
    addr_t            load_addr;
    addr_t            rd_addr;
    word_t            load_data;
    slave_id_t        slave_id [MASTER_COUNT];
    rw_op_e           rw [MASTER_COUNT];
    addr_t            first_addr [MASTER_COUNT];
    addr_t            last_addr [MASTER_COUNT];
    logic             done [MASTER_COUNT];
    logic             req [MASTER_COUNT];
    logic             gnt [MASTER_COUNT];
    slave_id_t        req_slave [MASTER_COUNT];

    serial_link_if m_link [MASTER_COUNT] ();   // master to router
    serial_link_if s_link [SLAVE_COUNT] ();    // router to slave

    session_ctrl #(
        .MASTER_COUNT(MASTER_COUNT),
        .SLAVE_DEPTHS(SLAVE_DEPTHS)
    ) session_ctrl_i (
        .clk, .rstN, .step, .next_addr, .value, .state, .start,
        .load_en, .load_sel, .load_addr, .rd_addr, .load_data,
        .slave_id, .rw, .first_addr, .last_addr, .done
    );

    for (genvar m = 0; m < MASTER_COUNT; m++) begin : g_master
        logic sel_match;
        assign sel_match = (load_sel == IDX_W'(m));

        bus_master bus_master_i (
            .clk, .rstN, .start,
            .rw(rw[m]), .slave_id(slave_id[m]),
            .first_addr(first_addr[m]), .last_addr(last_addr[m]),
            .load_en, .load_addr, .load_data, .load_sel_match(sel_match),
            .rd_addr, .rd_data(rd_data[m]),
            .req(req[m]), .req_slave(req_slave[m]), .gnt(gnt[m]),
            .done(done[m]), .link(m_link[m])
        );
    end

    bus_router #(
        .MASTER_COUNT(MASTER_COUNT),
        .SLAVE_COUNT(SLAVE_COUNT)
    ) bus_router_i (
        .clk, .rstN, .req, .req_slave, .gnt, .m_link, .s_link
    );

    for (genvar s = 0; s < SLAVE_COUNT; s++) begin : g_slave
        bus_slave #(.DEPTH(SLAVE_DEPTHS[s])) bus_slave_i (
            .clk, .rstN, .link(s_link[s])
        );
    end

endmodule

`default_nettype wire

/* hw/serial_link_if.sv */
`default_nettype none

interface serial_link_if;

    logic ctrl;   // header bits, lsb first
    logic wdata;  // write data bits
    logic valid;  // qualifies ctrl and wdata
    logic last;   // final header bit of a read, final data bit of a write
    logic rdata;  // read data bits from the slave
    logic ready;  // qualifies rdata

    modport master (
        output ctrl, wdata, valid, last,
        input  rdata, ready
    );

    modport slave (
        input  ctrl, wdata, valid, last,
        output rdata, ready
    );

endinterface

`default_nettype wire

/* hw/session_ctrl.sv */
`default_nettype none

module session_ctrl import serial_bus_pkg::*; #(
    parameter int MASTER_COUNT     = 2,
    parameter int SLAVE_DEPTHS [3] = '{256, 256, 128},
    localparam int IDX_W           = (MASTER_COUNT > 1) ? $clog2(MASTER_COUNT) : 1
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             step,
    input  logic             next_addr,
    input  word_t            value,
    output session_state_e   state,
    output logic             start,
    output logic             load_en,
    output logic [IDX_W-1:0] load_sel,
    output addr_t            load_addr,
    output addr_t            rd_addr,
    output word_t            load_data,
    output slave_id_t        slave_id [MASTER_COUNT],
    output rw_op_e           rw [MASTER_COUNT],
    output addr_t            first_addr [MASTER_COUNT],
    output addr_t            last_addr [MASTER_COUNT],
    input  logic             done [MASTER_COUNT]
);

    logic [IDX_W-1:0] idx;   // master being set up
    logic             last_master;
    logic             all_done;

    // keep the last address inside the target slave
    function automatic addr_t clamp_last(addr_t first, addr_t count, slave_id_t sid);
        logic [ADDR_W:0] sum;
        logic [ADDR_W:0] limit;
        sum   = {1'b0, first} + {1'b0, count};
        limit = {1'b0, {ADDR_W{1'b1}}};
        for (int s = 0; s < 3; s++) begin
            if (sid == slave_id_t'(s + 1))
                limit = (ADDR_W + 1)'(SLAVE_DEPTHS[s] - 1);
        end
        return (sum > limit) ? addr_t'(limit) : addr_t'(sum);
    endfunction

    assign last_master = (idx == IDX_W'(MASTER_COUNT - 1));
    assign load_en     = (state == load_words) && next_addr;
    assign load_sel    = idx;
    assign load_data   = value;

    always_comb begin
        all_done = !start;   // done levels are stale while start is high
        for (int m = 0; m < MASTER_COUNT; m++) begin
            if ((slave_id[m] != '0) && !done[m])
                all_done = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= slave_sel;
            start      <= 1'b0;
            idx        <= '0;
            load_addr  <= '0;
            rd_addr    <= '0;
            slave_id   <= '{default: '0};
            rw         <= '{default: op_read};
            first_addr <= '{default: '0};
            last_addr  <= '{default: '0};
        end else begin
            start <= 1'b0;
            case (state)
                slave_sel: begin
                    if (step) begin
                        for (int m = 0; m < MASTER_COUNT; m++)
                            slave_id[m] <= value[2*m +: 2];
                        state <= (value[2*MASTER_COUNT-1:0] == '0) ? com_done : rw_sel;
                    end
                end
                rw_sel: begin
                    if (step) begin
                        for (int m = 0; m < MASTER_COUNT; m++)
                            rw[m] <= rw_op_e'(value[m]);   // 1 is write
                        idx   <= '0;
                        state <= first_sel;
                    end
                end
                first_sel: begin
                    if (step) begin
                        first_addr[idx] <= value[ADDR_W-1:0];
                        idx             <= last_master ? '0 : idx + 1'b1;
                        if (last_master)
                            state <= count_sel;
                    end
                end
                count_sel: begin
                    if (step) begin
                        last_addr[idx] <= clamp_last(first_addr[idx], value[ADDR_W-1:0],
                                                     slave_id[idx]);
                        if (last_master) begin
                            idx       <= '0;
                            load_addr <= first_addr[0];
                            state     <= load_words;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                load_words: begin
                    if (step) begin
                        if (last_master) begin
                            state <= com_ready;
                        end else begin
                            idx       <= idx + 1'b1;
                            load_addr <= first_addr[idx + 1'b1];
                        end
                    end else if (next_addr) begin
                        load_addr <= load_addr + 1'b1;
                    end
                end
                com_ready: begin
                    if (step) begin
                        start <= 1'b1;
                        state <= communicating;
                    end
                end
                communicating: begin
                    if (all_done)
                        state <= com_done;
                end
                com_done: begin
                    if (next_addr)
                        rd_addr <= value[ADDR_W-1:0];
                    if (step)
                        state <= slave_sel;   // new session, memories keep their words
                end
                default: state <= slave_sel;
            endcase
        end
    end

endmodule

`default_nettype wire

/* sim/serial_bus_tb.sv */
`default_nettype none

module serial_bus_tb import serial_bus_pkg::*; ();

    localparam int    MASTER_COUNT  = 2;
    localparam int    STATE_TIMEOUT = 2000;   // cycles, longest session is far below
    localparam int    RESET_TIMEOUT = 20;
    localparam string TEST_FILE     = "sim/serial_bus_tests.txt";

    logic           clk;
    logic           rstN;
    logic           step;
    logic           next_addr;
    word_t          value;
    session_state_e state;
    word_t          rd_data [MASTER_COUNT];

    int    fd;
    int    line_no;
    int    checks;
    string line;

    tb_clock #(.PERIOD(10), .RESET_CYCLES(2)) tb_clock_i (.clk, .rstN);

    serial_bus_top #(.MASTER_COUNT(MASTER_COUNT)) serial_bus_top_i (
        .clk, .rstN, .step, .next_addr, .value, .state, .rd_data
    );

    task automatic fail_run();
        $display("Regression failed");
        $fatal(1, "serial bus run stopped");
    endtask

    task automatic reject_line(input string text);
        $display("cannot use test file line %0d: %s", line_no, text);
        fail_run();
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rstN !== 1'b1) begin
            if (cycles == RESET_TIMEOUT) begin
                $display("reset was never released");
                fail_run();
            end
            @(posedge clk);
            cycles++;
        end
        @(posedge clk);
        #1;
    endtask

    // one-cycle strobe on step or next_addr, driven just after the edge
    task automatic strobe_input(input logic is_step, input word_t v);
        @(posedge clk);
        #1;
        value = v;
        if (is_step)
            step = 1'b1;
        else
            next_addr = 1'b1;
        @(posedge clk);
        #1;
        step      = 1'b0;
        next_addr = 1'b0;
    endtask

    task automatic wait_for_state(input string tname, input int target);
        int cycles;
        cycles = 0;
        while (state != session_state_e'(target)) begin
            if (cycles == STATE_TIMEOUT) begin
                $display("timeout in %s: waited for state %0d, still in %s",
                         tname, target, state.name());
                fail_run();
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic check_readback(input string tname, input int master, input int addr,
                                  input int expected);
        word_t exp_word;
        word_t act_word;
        exp_word = word_t'(expected);
        act_word = '0;
        if (master >= MASTER_COUNT) begin
            $display("%s names master %0d, which does not exist", tname, master);
            fail_run();
        end
        strobe_input(1'b0, word_t'(addr));   // rd_addr latched here
        repeat (2) @(posedge clk);           // memory read, then rd_data settles
        #1;
        for (int m = 0; m < MASTER_COUNT; m++) begin
            if (m == master)
                act_word = rd_data[m];
        end
        checks++;
        assert (act_word == exp_word)
            else begin
                $display("ERR %s: expected %h, actual %h", tname, exp_word, act_word);
                fail_run();
            end
    endtask

    task automatic run_line(input string text);
        string cmd;
        string tname;
        int    nf;
        int    a;
        int    b;
        int    c;
        nf = $sscanf(text, "%s", cmd);
        if (nf < 1)
            return;                      // blank line
        if (cmd.substr(0, 0) == "#")
            return;
        if (cmd == "step") begin
            if ($sscanf(text, "%s %h", cmd, a) != 2)
                reject_line(text);
            strobe_input(1'b1, word_t'(a));
        end else if (cmd == "next") begin
            if ($sscanf(text, "%s %h", cmd, a) != 2)
                reject_line(text);
            strobe_input(1'b0, word_t'(a));
        end else if (cmd == "wait_state") begin
            if ($sscanf(text, "%s %s %h", cmd, tname, a) != 3)
                reject_line(text);
            wait_for_state(tname, a);
        end else if (cmd == "check") begin
            if ($sscanf(text, "%s %s %h %h %h", cmd, tname, a, b, c) != 5)
                reject_line(text);
            check_readback(tname, a, b, c);
        end else begin
            reject_line(text);
        end
    endtask

    initial begin
        step      = 1'b0;
        next_addr = 1'b0;
        value     = '0;
        checks    = 0;
        line_no   = 0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s", TEST_FILE);
            fail_run();
        end
        wait_reset_release();
        while ($fgets(line, fd) > 0) begin
            line_no++;
            run_line(line);
        end
        $fclose(fd);
        if (checks > 0) begin
            $display("%0d readback checks done", checks);
            $display("Regression passed");
            $finish;
        end else begin
            $display("the test file holds no readback checks");
            fail_run();
        end
    end

endmodule

`default_nettype wire

/* sim/serial_bus_tests.txt */
# step <value> | next <value> | wait_state <name> <state> | check <name> <master> <addr> <word>
# all numbers hex; states 0 slave_sel, 4 load_words, 5 com_ready, 7 com_done
wait_state after_reset 0
step 0000
wait_state no_slave_done 7
step 0000
wait_state back_to_setup 0
# master 0 writes slave 1 at 0a..0c, master 1 reads it back
step 0005
step 0001
step 000a
step 000a
step 0002
step 0002
wait_state a_loading 4
next 1234
next abcd
next 5a5a
step 0000
step 0000
wait_state a_ready 5
step 0000
wait_state a_done 7
check a_m0_w0 0 0a 1234
check a_m0_w1 0 0b abcd
check a_m0_w2 0 0c 5a5a
check a_m1_r0 1 0a 1234
check a_m1_r1 1 0b abcd
check a_m1_r2 1 0c 5a5a
step 0000
wait_state a_next 0
# one word to slave 3 at address 0
step 0003
step 0001
step 0000
step 0000
step 0000
step 0000
next beef
step 0000
step 0000
step 0000
wait_state b_done 7
check b_m0_w0 0 00 beef
step 0000
wait_state b_next 0
# write from 7e with count 5, slave 3 holds only up to 7f
step 0003
step 0001
step 007e
step 0000
step 0005
step 0000
next 1111
next 2222
next 3333
step 0000
step 0000
step 0000
wait_state c_done 7
check c_m0_w0 0 7e 1111
step 0000
wait_state c_next 0
# master 0 reads slave 3 address 0, master 1 reads 7e onwards
step 000f
step 0000
step 0000
step 007e
step 0000
step 0005
next 0000
step 0000
step 0000
step 0000
wait_state d_done 7
check d_m0_addr0 0 00 beef
check d_m1_r126 1 7e 1111
check d_m1_r127 1 7f 2222

/* sim/tb_clock.sv */
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstN = 1'b1;   // release away from the edge
    end

endmodule

`default_nettype wire
